//--- Bender.yml
package:
  name: cache_subsys

sources:
  # packages before the modules that import them
  - src/cache_pkg.sv
  - src/mem_pkg.sv
  - src/cache_array.sv
  - src/cache_cntrl.sv
  - src/mem_arbiter.sv
  - src/main_mem.sv
  - src/cache_subsys.sv
  - target: simulation
    files:
      - bench/cache_subsys_sva.sv
      - bench/cache_subsys_tb.sv

//--- bench/cache_subsys_sva.sv
`timescale 1ns/1ps

module cache_subsys_sva
    import cache_pkg::*;
    import mem_pkg::*;
(
    input logic                 clk,
    input logic                 rst_n,
    input cpu_req_t             icpu_req,
    input cpu_req_t             dcpu_req,
    input logic                 i_done,
    input logic                 d_done,
    input logic                 i_stall,
    input logic                 d_stall,
    input logic                 i_cache_hit,
    input logic                 d_cache_hit,
    input logic [NUM_PORTS-1:0] gnt,
    input logic [NUM_PORTS-1:0] req_line
);

    int unsigned          fail_cnt = 0;
    logic [NUM_PORTS-1:0] done_v, stall_v, hit_v, req_v;

    // bit 0 is the i port, bit 1 the d port
    assign done_v  = {d_done, i_done};
    assign stall_v = {d_stall, i_stall};
    assign hit_v   = {d_cache_hit, i_cache_hit};
    assign req_v   = {dcpu_req.rd || dcpu_req.wr, icpu_req.rd || icpu_req.wr};

    function automatic void flag_failure(input string what);
        fail_cnt++;
        $error("%s", what);
    endfunction

    a_one_owner: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt))
        else flag_failure("both ports hold the memory grant");

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        a_gnt_hold: assert property (@(posedge clk) disable iff (!rst_n)
            (gnt[p] && req_line[p]) |=> gnt[p])
            else flag_failure("grant moved while the owner still requested");
        a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
            done_v[p] |=> !done_v[p])
            else flag_failure("done held longer than one cycle");
        a_done_stall: assert property (@(posedge clk) disable iff (!rst_n)
            done_v[p] |-> (stall_v[p] && $past(stall_v[p])))
            else flag_failure("done without stall in the cycle before");
        a_hit_timing: assert property (@(posedge clk) disable iff (!rst_n)
            hit_v[p] |-> (done_v[p] && $past(stall_v[p]) && !$past(stall_v[p], 2)))
            else flag_failure("hit did not finish two cycles after acceptance");
        a_stall_start: assert property (@(posedge clk) disable iff (!rst_n)
            $rose(stall_v[p]) |-> $past(req_v[p]))
            else flag_failure("stall rose without an accepted request");
    end

endmodule

bind cache_subsys cache_subsys_sva u_sva (.*);

//--- bench/cache_subsys_tb.sv
`timescale 1ns/1ps

module cache_subsys_tb
    import cache_pkg::*;
    import mem_pkg::*;
();

    localparam int CLK_PERIOD  = 10;
    localparam int RST_CYCLES  = 4;
    localparam int NUM_OPS     = 200;   // per port
    localparam int OP_CYCLES   = 40;    // budget for one access
    localparam int WATCHDOG_NS = (NUM_PORTS * NUM_OPS * OP_CYCLES + RST_CYCLES) * CLK_PERIOD;

    logic              clk;
    logic              rst_n;
    cpu_req_t          icpu_req;
    cpu_req_t          dcpu_req;
    logic [WORD_W-1:0] i_data_out;
    logic [WORD_W-1:0] d_data_out;
    logic              i_done, d_done;
    logic              i_stall, d_stall;
    logic              i_cache_hit, d_cache_hit;

    logic [WORD_W-1:0] exp_data [NUM_PORTS];   // expected read data
    logic              chk_rd   [NUM_PORTS];
    logic              chk_hit  [NUM_PORTS];   // read right after a write

    bit [WORD_W-1:0] shadow [MEM_WORDS];       // memory image, starts at zero
    cpu_req_t        ops    [NUM_PORTS][NUM_OPS];
    bit              follow [NUM_PORTS][NUM_OPS];
    integer          seed    = 32'h84e7;

    cache_subsys uut (
        .clk(clk), .rst_n(rst_n), .icpu_req(icpu_req), .dcpu_req(dcpu_req),
        .i_data_out(i_data_out), .d_data_out(d_data_out),
        .i_done(i_done), .d_done(d_done), .i_stall(i_stall), .d_stall(d_stall),
        .i_cache_hit(i_cache_hit), .d_cache_hit(d_cache_hit)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic report_mismatch(input string name, input logic [WORD_W-1:0] got,
                                   input logic [WORD_W-1:0] exp);
        stop_with_failure($sformatf("Error at %0t ns: %s = 0x%04h, expected 0x%04h",
                                    $time, name, got, exp));
    endtask

    // three tags over four lines, so lines get reused, evicted and refilled
    task automatic gen_ops(input int port);
        logic [TAG_W-1:0]   tags [3] = '{5'h02, 5'h05, 5'h0b};
        logic [INDEX_W-1:0] idxs [4] = '{8'h03, 8'h04, 8'h41, 8'hc7};
        logic [TAG_W-1:0]   tag;
        logic [31:0]        r;
        cpu_req_t           op;
        int                 k;
        k = 0;
        while (k < NUM_OPS) begin
            r        = $random(seed);
            tag      = tags[r[7:4] % 3];
            tag[4]   = (port == PORT_D);       // d port lives in the upper half
            op       = '0;
            op.wr    = r[0];
            op.rd    = !r[0];
            op.addr  = {tag, idxs[r[9:8]], r[11:10], 1'b0};
            op.wdata = r[31:16];
            ops[port][k]    = op;
            follow[port][k] = 1'b0;
            k++;
            if (op.wr && k < NUM_OPS && r[13:12] == 2'b00) begin
                op.wr           = 1'b0;
                op.rd           = 1'b1;
                op.wdata        = '0;
                ops[port][k]    = op;
                follow[port][k] = 1'b1;
                k++;
            end
        end
    endtask

    // starts on a falling edge and holds the request until done
    task automatic do_access(input int port, input cpu_req_t op, input bit is_follow);
        logic [MEM_ADDR_W-2:0] waddr;
        int                    cycles;
        logic                  seen;
        waddr          = op.addr[MEM_ADDR_W-1:1];
        exp_data[port] = shadow[waddr];
        chk_rd[port]   = op.rd;
        chk_hit[port]  = is_follow;
        if (port == PORT_I)
            icpu_req = op;
        else
            dcpu_req = op;
        if (op.wr)
            shadow[waddr] = op.wdata;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < OP_CYCLES) begin
            @(negedge clk);
            cycles++;
            seen = (port == PORT_I) ? i_done : d_done;
        end
        if (!seen)
            stop_with_failure($sformatf("port %0d: access to 0x%04h still stalled after %0d cycles",
                                        port, op.addr, OP_CYCLES));
        @(negedge clk);   // done is sampled at the edge in between
        chk_rd[port]  = 1'b0;
        chk_hit[port] = 1'b0;
        if (port == PORT_I)
            icpu_req = '0;
        else
            dcpu_req = '0;
    endtask

    // ========================================
    // checks
    // ========================================
    i_read_data: assert property (@(posedge clk) disable iff (!rst_n)
        (i_done && chk_rd[PORT_I]) |-> (i_data_out == exp_data[PORT_I]))
        else report_mismatch("i_data_out", i_data_out, exp_data[PORT_I]);

    d_read_data: assert property (@(posedge clk) disable iff (!rst_n)
        (d_done && chk_rd[PORT_D]) |-> (d_data_out == exp_data[PORT_D]))
        else report_mismatch("d_data_out", d_data_out, exp_data[PORT_D]);

    i_read_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        (i_done && chk_hit[PORT_I]) |-> i_cache_hit)
        else stop_with_failure("port i: read right after a write of the same word missed");

    d_read_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        (d_done && chk_hit[PORT_D]) |-> d_cache_hit)
        else stop_with_failure("port d: read right after a write of the same word missed");

    // ========================================
    // clock, stimulus, watchdog
    // ========================================
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n    = 1'b0;
        icpu_req = '0;
        dcpu_req = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_data[p] = '0;
            chk_rd[p]   = 1'b0;
            chk_hit[p]  = 1'b0;
        end
        gen_ops(PORT_I);
        gen_ops(PORT_D);
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        fork
            for (int k = 0; k < NUM_OPS; k++)
                do_access(PORT_I, ops[PORT_I][k], follow[PORT_I][k]);
            for (int k = 0; k < NUM_OPS; k++)
                do_access(PORT_D, ops[PORT_D][k], follow[PORT_D][k]);
        join
        repeat (4) @(negedge clk);
        if (uut.u_sva.fail_cnt == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "run ended with failed checks");
        end
    end

    initial begin
        wait (uut.u_sva.fail_cnt != 0);
        stop_with_failure("a bound protocol assertion failed");
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("watchdog expired before all accesses completed");
    end

endmodule

//--- filelist.f
src/cache_pkg.sv
src/mem_pkg.sv
src/cache_array.sv
src/cache_cntrl.sv
src/mem_arbiter.sv
src/main_mem.sv
src/cache_subsys.sv
bench/cache_subsys_sva.sv
bench/cache_subsys_tb.sv

//--- src/cache_array.sv
`timescale 1ns/1ps

module cache_array
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  arr_cmd_t cmd,
    output arr_rsp_t rsp
);

    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;
    logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
    logic [WORD_W-1:0]    data_mem [NUM_LINES][WORDS_PER_LINE];
    logic                 wr_hit;
    logic                 wr_fill;

    // lookup is combinational on the command
    always_comb begin
        rsp.valid   = valid_q[cmd.index];
        rsp.dirty   = dirty_q[cmd.index];
        rsp.tag_out = tag_mem[cmd.index];
        rsp.rdata   = data_mem[cmd.index][cmd.offset];
        rsp.hit     = valid_q[cmd.index] && (tag_mem[cmd.index] == cmd.tag);
    end

    assign wr_hit  = cmd.en && cmd.write && cmd.comp && rsp.hit;
    assign wr_fill = cmd.en && cmd.write && cmd.fill;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_fill) begin
            valid_q[cmd.index] <= 1'b1;
            dirty_q[cmd.index] <= 1'b0;    // fresh copy of memory
        end else if (wr_hit) begin
            dirty_q[cmd.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fill)
            tag_mem[cmd.index] <= cmd.tag;
        if (wr_fill || wr_hit)
            data_mem[cmd.index][cmd.offset] <= cmd.wdata;
    end

endmodule

//--- src/cache_cntrl.sv
`timescale 1ns/1ps

module cache_cntrl
    import cache_pkg::*;
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_req_t          cpu_req,
    input  arr_rsp_t          arr_rsp,
    input  logic              gnt,
    input  mem_rsp_t          mem_rsp,
    output arr_cmd_t          arr_cmd,
    output mem_req_t          mem_req,
    output logic              mem_req_line,
    output logic [WORD_W-1:0] data_out,
    output logic              done,
    output logic              stall,
    output logic              cache_hit
);

    cntrl_state_e       state, nxt_state;
    logic [WSEL_W-1:0]  fill_cnt;     // refill words received
    logic               hit_q;
    logic [WORD_W-1:0]  result_q;
    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] req_index;
    logic [WSEL_W-1:0]  req_word;
    logic [WSEL_W-1:0]  burst_word;   // word of the current memory beat
    logic               fill_beat;

    // address fields of the held request
    assign req_tag   = cpu_req.addr[ADDR_W-1 -: TAG_W];
    assign req_index = cpu_req.addr[OFFSET_W +: INDEX_W];
    assign req_word  = cpu_req.addr[OFFSET_W-1 -: WSEL_W];

    assign fill_beat = gnt && mem_rsp.rvalid && (state inside {[FILL_REQ_0:FILL_WAIT]});

    // ========================================
    // next state and commands
    // ========================================
    always_comb begin
        nxt_state     = state;
        burst_word    = '0;
        arr_cmd       = '0;
        arr_cmd.index = req_index;
        arr_cmd.tag   = req_tag;
        mem_req.op    = MEM_NOP;
        mem_req.addr  = '0;
        mem_req.wdata = '0;
        case (state)
            IDLE: begin
                if (cpu_req.rd)
                    nxt_state = COMP_RD;
                else if (cpu_req.wr)
                    nxt_state = COMP_WR;
            end
            COMP_RD, COMP_WR: begin
                arr_cmd.en     = 1'b1;
                arr_cmd.comp   = 1'b1;
                arr_cmd.write  = (state == COMP_WR);  // array only writes on a hit
                arr_cmd.offset = req_word;
                arr_cmd.wdata  = cpu_req.wdata;
                if (arr_rsp.hit)
                    nxt_state = DONE;
                else if (arr_rsp.valid && arr_rsp.dirty)
                    nxt_state = WAIT_GNT_WB;
                else
                    nxt_state = WAIT_GNT_FILL;
            end
            WAIT_GNT_WB: begin
                if (gnt)
                    nxt_state = WB_0;
            end
            WB_0, WB_1, WB_2, WB_3: begin
                burst_word     = WSEL_W'(state - WB_0);
                arr_cmd.en     = 1'b1;
                arr_cmd.offset = burst_word;
                mem_req.op     = MEM_WR;
                mem_req.addr   = {arr_rsp.tag_out, req_index, burst_word,
                                  {(OFFSET_W - WSEL_W){1'b0}}};  // victim line
                mem_req.wdata  = arr_rsp.rdata;
                // grant is kept, go straight on to the refill
                nxt_state = (state == WB_3) ? FILL_REQ_0 : cntrl_state_e'(state + 1'b1);
            end
            WAIT_GNT_FILL: begin
                if (gnt)
                    nxt_state = FILL_REQ_0;
            end
            FILL_REQ_0, FILL_REQ_1, FILL_REQ_2, FILL_REQ_3: begin
                burst_word   = WSEL_W'(state - FILL_REQ_0);
                mem_req.op   = MEM_RD;
                mem_req.addr = {req_tag, req_index, burst_word, {(OFFSET_W - WSEL_W){1'b0}}};
                nxt_state    = cntrl_state_e'(state + 1'b1);  // FILL_REQ_3 leads to FILL_WAIT
            end
            FILL_WAIT: begin
                if (fill_beat && fill_cnt == WSEL_W'(WORDS_PER_LINE - 1))
                    nxt_state = MERGE;
            end
            MERGE: begin
                // pending write lands on the refilled line and marks it dirty
                if (cpu_req.wr) begin
                    arr_cmd.en     = 1'b1;
                    arr_cmd.comp   = 1'b1;
                    arr_cmd.write  = 1'b1;
                    arr_cmd.offset = req_word;
                    arr_cmd.wdata  = cpu_req.wdata;
                end
                nxt_state = DONE;
            end
            DONE: nxt_state = IDLE;
            default: nxt_state = IDLE;
        endcase

        if (fill_beat) begin
            arr_cmd.en     = 1'b1;
            arr_cmd.write  = 1'b1;
            arr_cmd.fill   = 1'b1;
            arr_cmd.offset = fill_cnt;
            arr_cmd.wdata  = mem_rsp.rdata;
        end
    end

    // ========================================
    // registers
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            fill_cnt <= '0;
            hit_q    <= 1'b0;
        end else begin
            state <= nxt_state;
            if (state inside {COMP_RD, COMP_WR}) begin
                hit_q    <= arr_rsp.hit;
                fill_cnt <= '0;
            end else if (fill_beat) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == COMP_RD)
            result_q <= arr_rsp.rdata;
        else if (fill_beat && fill_cnt == req_word)
            result_q <= mem_rsp.rdata;  // requested word on its way in
    end

    assign mem_req_line = state inside {[WAIT_GNT_WB:FILL_WAIT]};
    assign stall        = (state != IDLE);
    assign done         = (state == DONE);
    assign cache_hit    = done && hit_q;
    assign data_out     = result_q;

endmodule

//--- src/cache_pkg.sv
package cache_pkg;

    // ========================================
    // geometry
    // ========================================
    localparam int ADDR_W         = 16;   // byte address
    localparam int WORD_W         = 16;
    localparam int TAG_W          = 5;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 3;    // byte offset inside a line
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_LINES      = 256;
    localparam int WSEL_W         = $clog2(WORDS_PER_LINE);

    // ========================================
    // controller FSM
    // ========================================
    typedef enum logic [4:0] {
        IDLE,
        COMP_RD,
        COMP_WR,
        WAIT_GNT_WB,
        WB_0, WB_1, WB_2, WB_3,                      // victim words out
        WAIT_GNT_FILL,
        FILL_REQ_0, FILL_REQ_1, FILL_REQ_2, FILL_REQ_3,  // refill reads issued
        FILL_WAIT,
        MERGE,
        DONE
    } cntrl_state_e;

    typedef struct packed {
        logic              rd;
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic               en;
        logic               comp;
        logic               write;
        logic               fill;
        logic [INDEX_W-1:0] index;
        logic [WSEL_W-1:0]  offset;   // word within the line
        logic [TAG_W-1:0]   tag;
        logic [WORD_W-1:0]  wdata;
    } arr_cmd_t;

    typedef struct packed {
        logic              hit;
        logic              dirty;
        logic              valid;
        logic [TAG_W-1:0]  tag_out;
        logic [WORD_W-1:0] rdata;
    } arr_rsp_t;

endpackage

//--- src/cache_subsys.sv
`timescale 1ns/1ps

module cache_subsys
    import cache_pkg::*;
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_req_t          icpu_req,
    input  cpu_req_t          dcpu_req,
    output logic [WORD_W-1:0] i_data_out,
    output logic [WORD_W-1:0] d_data_out,
    output logic              i_done,
    output logic              d_done,
    output logic              i_stall,
    output logic              d_stall,
    output logic              i_cache_hit,
    output logic              d_cache_hit
);

    arr_cmd_t             i_arr_cmd, d_arr_cmd;
    arr_rsp_t             i_arr_rsp, d_arr_rsp;
    mem_req_t             port_req [NUM_PORTS];
    logic [NUM_PORTS-1:0] req_line;
    logic [NUM_PORTS-1:0] gnt;
    mem_req_t             mem_req;
    mem_rsp_t             mem_rsp;   // seen by both controllers

    // ========================================
    // instruction side
    // ========================================
    cache_cntrl u_icntrl (
        .clk(clk), .rst_n(rst_n), .cpu_req(icpu_req), .arr_rsp(i_arr_rsp),
        .gnt(gnt[PORT_I]), .mem_rsp(mem_rsp), .arr_cmd(i_arr_cmd),
        .mem_req(port_req[PORT_I]), .mem_req_line(req_line[PORT_I]),
        .data_out(i_data_out), .done(i_done), .stall(i_stall), .cache_hit(i_cache_hit)
    );

    cache_array u_iarray (.clk(clk), .rst_n(rst_n), .cmd(i_arr_cmd), .rsp(i_arr_rsp));

    // ========================================
    // data side
    // ========================================
    cache_cntrl u_dcntrl (
        .clk(clk), .rst_n(rst_n), .cpu_req(dcpu_req), .arr_rsp(d_arr_rsp),
        .gnt(gnt[PORT_D]), .mem_rsp(mem_rsp), .arr_cmd(d_arr_cmd),
        .mem_req(port_req[PORT_D]), .mem_req_line(req_line[PORT_D]),
        .data_out(d_data_out), .done(d_done), .stall(d_stall), .cache_hit(d_cache_hit)
    );

    cache_array u_darray (.clk(clk), .rst_n(rst_n), .cmd(d_arr_cmd), .rsp(d_arr_rsp));

    mem_arbiter u_arbiter (
        .clk(clk), .rst_n(rst_n), .req_line(req_line), .port_req(port_req),
        .gnt(gnt), .mem_req(mem_req)
    );

    main_mem u_mem (.clk(clk), .rst_n(rst_n), .req(mem_req), .rsp(mem_rsp));

endmodule

//--- src/main_mem.sv
`timescale 1ns/1ps

module main_mem
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t req,
    output mem_rsp_t rsp
);

    localparam int WADDR_W = $clog2(MEM_WORDS);

    logic [MEM_DATA_W-1:0] mem_array [MEM_WORDS] = '{default: '0};
    logic [WADDR_W-1:0]    waddr;
    logic [MEM_LATENCY-1:0] rvalid_pipe;
    logic [MEM_DATA_W-1:0] rdata_pipe [MEM_LATENCY];

    assign waddr = req.addr[MEM_ADDR_W-1:1];   // drop the byte bit

    // ========================================
    // read pipeline
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_pipe <= '0;
        end else begin
            rvalid_pipe[0] <= (req.op == MEM_RD);
            for (int s = 1; s < MEM_LATENCY; s++)
                rvalid_pipe[s] <= rvalid_pipe[s-1];
        end
    end

    always_ff @(posedge clk) begin
        if (req.op == MEM_WR)
            mem_array[waddr] <= req.wdata;
        rdata_pipe[0] <= mem_array[waddr];
        for (int s = 1; s < MEM_LATENCY; s++)
            rdata_pipe[s] <= rdata_pipe[s-1];
    end

    assign rsp.rvalid = rvalid_pipe[MEM_LATENCY-1];
    assign rsp.rdata  = rdata_pipe[MEM_LATENCY-1];

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
    import mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_PORTS-1:0] req_line,
    input  mem_req_t             port_req [NUM_PORTS],
    output logic [NUM_PORTS-1:0] gnt,
    output mem_req_t             mem_req
);

    logic [NUM_PORTS-1:0] owner;     // one-hot, zero when the bus is free
    logic [PORT_W-1:0]    last;      // last port served
    logic                 pick_vld;
    logic [PORT_W-1:0]    pick;

    // search starts just after the last served port
    always_comb begin
        int p;
        pick_vld = 1'b0;
        pick     = last;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            p = (int'(last) + k) % NUM_PORTS;
            if (!pick_vld && req_line[p]) begin
                pick_vld = 1'b1;
                pick     = PORT_W'(p);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner <= '0;
            last  <= PORT_W'(NUM_PORTS - 1);   // port 0 first
        end else if (!(|(owner & req_line))) begin
            owner <= pick_vld ? (NUM_PORTS'(1) << pick) : '0;
            if (pick_vld)
                last <= pick;
        end
    end

    assign gnt = owner;

    always_comb begin
        mem_req.op    = MEM_NOP;
        mem_req.addr  = '0;
        mem_req.wdata = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (owner[p])
                mem_req = port_req[p];
        end
    end

endmodule

//--- src/mem_pkg.sv
package mem_pkg;

    localparam int MEM_ADDR_W  = 16;      // byte address, word aligned
    localparam int MEM_DATA_W  = 16;
    localparam int MEM_WORDS   = 32768;
    localparam int MEM_LATENCY = 2;       // read request to rvalid

    // arbiter ports
    localparam int NUM_PORTS = 2;
    localparam int PORT_W    = $clog2(NUM_PORTS);
    localparam int PORT_I    = 0;
    localparam int PORT_D    = 1;

    typedef enum logic [1:0] {
        MEM_NOP,
        MEM_RD,
        MEM_WR
    } mem_op_e;

    typedef struct packed {
        mem_op_e               op;
        logic [MEM_ADDR_W-1:0] addr;
        logic [MEM_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                  rvalid;
        logic [MEM_DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage
